// File: src/issue_pkg.sv
package issue_pkg;

    // --------------------------------------------------
    // Widths and sizes
    // --------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Issue to write-back, in clock cycles
    localparam int EX_LATENCY = 2;

    // Up to three outstanding writes per register
    localparam int PEND_W     = 2;

    // --------------------------------------------------
    // ALU operations
    // --------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_NOP
    } alu_op_t;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 codes, base and SUB/alternate shift
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

endpackage

// File: src/instr_decoder.sv
module instr_decoder import issue_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  instr_valid_i,
    input  logic [XLEN-1:0]       instr_i,
    input  logic                  regfile_stall_i,
    output logic                  stall_o,
    output logic                  issue_o,
    output logic                  read_rs1_o,
    output logic                  read_rs2_o,
    output logic                  write_rd_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [XLEN-1:0]       imm_o,
    output logic                  use_imm_o,
    output alu_op_t               alu_op_o
);

    logic            slot_valid_q;
    logic [XLEN-1:0] slot_instr_q;
    logic            load;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;

    // --------------------------------------------------
    // Slot handshake
    // --------------------------------------------------
    assign issue_o = slot_valid_q && !regfile_stall_i;
    // Full and held back by the register file
    assign stall_o = slot_valid_q && !issue_o;
    assign load    = instr_valid_i && !stall_o;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            slot_valid_q <= 1'b0;
        end else if (load) begin
            slot_valid_q <= 1'b1;
        end else if (issue_o) begin
            slot_valid_q <= 1'b0;
        end
    end

    // Held instruction word
    always_ff @(posedge clk_i) begin
        if (load) begin
            slot_instr_q <= instr_i;
        end
    end

    // --------------------------------------------------
    // Field split
    // --------------------------------------------------
    assign opcode = slot_instr_q[6:0];
    assign funct3 = slot_instr_q[14:12];
    assign funct7 = slot_instr_q[31:25];
    assign rd_o   = slot_instr_q[11:7];
    assign rs1_o  = slot_instr_q[19:15];
    assign rs2_o  = slot_instr_q[24:20];
    // Sign-extended I-type immediate
    assign imm_o  = {{(XLEN-12){slot_instr_q[31]}}, slot_instr_q[31:20]};

    always_comb begin
        read_rs1_o = 1'b0;
        read_rs2_o = 1'b0;
        write_rd_o = 1'b0;
        use_imm_o  = 1'b0;
        alu_op_o   = ALU_NOP;
        if (slot_valid_q && opcode == OPC_OP) begin
            if (funct7 == F7_BASE) begin
                case (funct3)
                    F3_ADD_SUB: alu_op_o = ALU_ADD;
                    F3_SLL:     alu_op_o = ALU_SLL;
                    F3_SLT:     alu_op_o = ALU_SLT;
                    F3_XOR:     alu_op_o = ALU_XOR;
                    F3_SRL:     alu_op_o = ALU_SRL;
                    F3_OR:      alu_op_o = ALU_OR;
                    F3_AND:     alu_op_o = ALU_AND;
                    default:    alu_op_o = ALU_NOP;
                endcase
            end else if (funct7 == F7_ALT && funct3 == F3_ADD_SUB) begin
                alu_op_o = ALU_SUB;
            end
            // SRA and others stay NOP
            read_rs1_o = (alu_op_o != ALU_NOP);
            read_rs2_o = (alu_op_o != ALU_NOP);
            write_rd_o = (alu_op_o != ALU_NOP);
        end else if (slot_valid_q && opcode == OPC_OP_IMM) begin
            case (funct3)
                F3_ADD_SUB: alu_op_o = ALU_ADD;
                F3_AND:     alu_op_o = ALU_AND;
                F3_OR:      alu_op_o = ALU_OR;
                F3_XOR:     alu_op_o = ALU_XOR;
                default:    alu_op_o = ALU_NOP;
            endcase
            read_rs1_o = (alu_op_o != ALU_NOP);
            write_rd_o = (alu_op_o != ALU_NOP);
            use_imm_o  = (alu_op_o != ALU_NOP);
        end
    end

    // Held word survives every stalled edge
    a_hold_on_stall : assert property (@(posedge clk_i) disable iff (!rst_i)
        stall_o |=> $stable(slot_instr_q) && slot_valid_q);

endmodule

// File: src/register_file.sv
module register_file import issue_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  issue_i,
    input  logic                  read_rs1_i,
    input  logic                  read_rs2_i,
    input  logic                  write_rd_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic                  wb_valid_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o,
    output logic                  stall_o
);

    logic [XLEN-1:0]   regs_q [NUM_REGS];
    logic [PEND_W-1:0] pend_q [NUM_REGS];

    logic rs1_ready;
    logic rs2_ready;
    logic inc_en;
    logic dec_en;

    // --------------------------------------------------
    // Operand readiness
    // --------------------------------------------------
    // No write outstanding on the source
    assign rs1_ready = (pend_q[rs1_i] == '0);
    assign rs2_ready = (pend_q[rs2_i] == '0);

    // Data only for a flagged and ready source
    assign rs1_data_o = (read_rs1_i && rs1_ready) ? regs_q[rs1_i] : '0;
    assign rs2_data_o = (read_rs2_i && rs2_ready) ? regs_q[rs2_i] : '0;

    assign stall_o = (read_rs1_i && !rs1_ready) || (read_rs2_i && !rs2_ready);

    // --------------------------------------------------
    // Pending counters and write-back
    // --------------------------------------------------
    // x0 never counts
    assign inc_en = issue_i && write_rd_i && (rd_i != '0);
    assign dec_en = wb_valid_i && (wb_rd_i != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                pend_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                // Issue and write-back on the same register cancel
                case ({inc_en && rd_i == REG_ADDR_W'(i), dec_en && wb_rd_i == REG_ADDR_W'(i)})
                    2'b10:   pend_q[i] <= pend_q[i] + 1'b1;
                    2'b01:   pend_q[i] <= pend_q[i] - 1'b1;
                    default: pend_q[i] <= pend_q[i];
                endcase
            end
        end
    end

    // Registers cleared on reset, x0 pinned
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (dec_en) begin
            regs_q[wb_rd_i] <= wb_data_i;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    // Every write-back matches an earlier issue
    a_wb_has_pending : assert property (@(posedge clk_i) disable iff (!rst_i)
        dec_en |-> pend_q[wb_rd_i] != '0);

    // Saturated counter only bumped when a write-back retires in the same edge
    a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_i)
        inc_en |-> (pend_q[rd_i] != '1) || (dec_en && wb_rd_i == rd_i));

endmodule

// File: src/alu_pipe.sv
module alu_pipe import issue_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  valid_i,
    input  alu_op_t               alu_op_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic                  use_imm_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    // Stage 1 state
    logic                  s1_valid_q;
    alu_op_t               s1_op_q;
    logic [XLEN-1:0]       s1_a_q;
    logic [XLEN-1:0]       s1_b_q;
    logic [REG_ADDR_W-1:0] s1_rd_q;

    logic [XLEN-1:0]       result;

    // --------------------------------------------------
    // Stage 1 operand select
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_op_q <= alu_op_i;
        s1_a_q  <= rs1_data_i;
        // Immediate replaces rs2 for I-type
        s1_b_q  <= use_imm_i ? imm_i : rs2_data_i;
        s1_rd_q <= rd_i;
    end

    // --------------------------------------------------
    // Stage 2 compute and write-back
    // --------------------------------------------------
    always_comb begin
        case (s1_op_q)
            ALU_ADD: result = s1_a_q + s1_b_q;
            ALU_SUB: result = s1_a_q - s1_b_q;
            ALU_AND: result = s1_a_q & s1_b_q;
            ALU_OR:  result = s1_a_q | s1_b_q;
            ALU_XOR: result = s1_a_q ^ s1_b_q;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(s1_a_q) < $signed(s1_b_q)};
            // Shift amount from the low five bits
            ALU_SLL: result = s1_a_q << s1_b_q[4:0];
            ALU_SRL: result = s1_a_q >> s1_b_q[4:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            // NOP and x0 targets retire silently
            wb_valid_o <= s1_valid_q && (s1_op_q != ALU_NOP) && (s1_rd_q != '0);
        end
    end

    always_ff @(posedge clk_i) begin
        wb_rd_o   <= s1_rd_q;
        wb_data_o <= result;
    end

    a_wb_rd_nonzero : assert property (@(posedge clk_i) disable iff (!rst_i)
        wb_valid_o |-> wb_rd_o != '0);

endmodule

// File: src/issue_core.sv
module issue_core import issue_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  instr_valid_i,
    input  logic [XLEN-1:0]       instr_i,
    output logic                  stall_o,
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    // Decoder to register file and ALU
    logic                  issue;
    logic                  read_rs1;
    logic                  read_rs2;
    logic                  write_rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
    alu_op_t               alu_op;

    // Register file outputs
    logic                  regfile_stall;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    // --------------------------------------------------
    // Issue slot
    // --------------------------------------------------
    instr_decoder u_instr_decoder (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .regfile_stall_i (regfile_stall),
        .stall_o         (stall_o),
        .issue_o         (issue),
        .read_rs1_o      (read_rs1),
        .read_rs2_o      (read_rs2),
        .write_rd_o      (write_rd),
        .rs1_o           (rs1),
        .rs2_o           (rs2),
        .rd_o            (rd),
        .imm_o           (imm),
        .use_imm_o       (use_imm),
        .alu_op_o        (alu_op)
    );

    // Scoreboarded registers, write-back fed from the ALU
    register_file u_register_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .issue_i    (issue),
        .read_rs1_i (read_rs1),
        .read_rs2_i (read_rs2),
        .write_rd_i (write_rd),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (rd),
        .wb_valid_i (wb_valid_o),
        .wb_rd_i    (wb_rd_o),
        .wb_data_i  (wb_data_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .stall_o    (regfile_stall)
    );

    // --------------------------------------------------
    // Execute
    // --------------------------------------------------
    alu_pipe u_alu_pipe (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .valid_i    (issue),
        .alu_op_i   (alu_op),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .imm_i      (imm),
        .use_imm_i  (use_imm),
        .rd_i       (rd),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

// File: testbench/tb_issue_core.sv
module tb_issue_core import issue_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    // Instructions sent over all tests
    localparam int NUM_INSTR  = 55;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * (EX_LATENCY + 4) + 120;

    logic                  clk_i;
    logic                  rst_i;
    logic                  instr_valid_i;
    logic [XLEN-1:0]       instr_i;
    logic                  stall_o;
    logic                  wb_valid_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;

    // Reference state in program order
    logic [XLEN-1:0]       mirror [NUM_REGS];
    logic [REG_ADDR_W-1:0] exp_rd [256];
    logic [XLEN-1:0]       exp_data [256];
    int                    wb_head;
    int                    wb_tail;

    // Side info for the word on instr_i
    logic                  acc_writes;
    logic [REG_ADDR_W-1:0] acc_rd;
    logic                  acc_raw;
    logic                  timing_mode;
    logic                  accept;

    integer seed;
    int     fail_count;
    int     test_num;
    int     test_start_fails;
    int     tests_ok;
    int     tests_bad;
    int     sent_count;

    issue_core u_issue_core (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .stall_o       (stall_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    assign accept = instr_valid_i && !stall_o;

    // Retire the queue head on each write-back
    always @(posedge clk_i) begin
        if (!rst_i) begin
            wb_head <= 0;
        end else if (wb_valid_o) begin
            wb_head <= wb_head + 1;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_reset_idle : assert property (@(posedge clk_i) !rst_i |=> !stall_o && !wb_valid_o)
        else begin
            $display("Outputs not idle after reset at %0t", $time);
            fail_count++;
        end

    // Every write-back matches the oldest expected one
    a_wb_order : assert property (@(posedge clk_i) disable iff (!rst_i)
        wb_valid_o |-> wb_head != wb_tail && wb_rd_o == exp_rd[wb_head[7:0]]
            && wb_data_o == exp_data[wb_head[7:0]])
        else begin
            $display("FAIL %0t: write-back x%0d = %h, expected x%0d = %h (%0d queued)",
                $time, $sampled(wb_rd_o), $sampled(wb_data_o),
                exp_rd[$sampled(wb_head[7:0])], exp_data[$sampled(wb_head[7:0])],
                wb_tail - $sampled(wb_head));
            fail_count++;
        end

    a_three_cycles : assert property (@(posedge clk_i) disable iff (!rst_i)
        accept && acc_writes && timing_mode |-> ##3 (wb_valid_o && wb_rd_o == $past(acc_rd, 3)))
        else begin
            $display("FAIL %0t: write-back not three cycles after acceptance", $time);
            fail_count++;
        end

    a_no_stall_stream : assert property (@(posedge clk_i) disable iff (!rst_i)
        timing_mode |-> !stall_o)
        else begin
            $display("Unexpected stall at %0t in the independent stream", $time);
            fail_count++;
        end

    // Dependent word right behind its producer must wait
    a_raw_stalls : assert property (@(posedge clk_i) disable iff (!rst_i)
        accept && acc_raw |=> stall_o)
        else begin
            $display("No stall at %0t for a dependent instruction", $time);
            fail_count++;
        end

    // --------------------------------------------------
    // Encoding and reference model
    // --------------------------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    // Ops 0..7 are R-type and 8..11 I-type
    function automatic logic [31:0] op_word(input int k, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
        case (k)
            0:       return enc_r(F7_BASE, F3_ADD_SUB, rd, rs1, rs2);
            1:       return enc_r(F7_ALT, F3_ADD_SUB, rd, rs1, rs2);
            2:       return enc_r(F7_BASE, F3_AND, rd, rs1, rs2);
            3:       return enc_r(F7_BASE, F3_OR, rd, rs1, rs2);
            4:       return enc_r(F7_BASE, F3_XOR, rd, rs1, rs2);
            5:       return enc_r(F7_BASE, F3_SLT, rd, rs1, rs2);
            6:       return enc_r(F7_BASE, F3_SLL, rd, rs1, rs2);
            7:       return enc_r(F7_BASE, F3_SRL, rd, rs1, rs2);
            8:       return enc_i(imm, F3_ADD_SUB, rd, rs1);
            9:       return enc_i(imm, F3_AND, rd, rs1);
            10:      return enc_i(imm, F3_OR, rd, rs1);
            default: return enc_i(imm, F3_XOR, rd, rs1);
        endcase
    endfunction

    function automatic logic [4:0] pick_reg(input int lo, input int span);
        int r;
        r = $random(seed);
        return 5'(lo + (r & 16'hffff) % span);
    endfunction

    function automatic logic [11:0] rand_imm();
        int r;
        r = $random(seed);
        return r[11:0];
    endfunction

    // RV32I result from the mirror with writes low for unsupported words
    task automatic predict(input logic [31:0] ins, output logic writes, output logic [31:0] res);
        logic [31:0] a;
        logic [31:0] b;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        opc = ins[6:0];
        f3 = ins[14:12];
        f7 = ins[31:25];
        a = mirror[ins[19:15]];
        b = (opc == OPC_OP) ? mirror[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        writes = 1'b1;
        res = 32'h0;
        if (opc == OPC_OP && f7 == 7'h00) begin
            case (f3)
                3'b000:  res = a + b;
                3'b001:  res = a << b[4:0];
                3'b010:  res = {31'h0, $signed(a) < $signed(b)};
                3'b100:  res = a ^ b;
                3'b101:  res = a >> b[4:0];
                3'b110:  res = a | b;
                3'b111:  res = a & b;
                default: writes = 1'b0;
            endcase
        end else if (opc == OPC_OP && f7 == 7'h20 && f3 == 3'b000) begin
            res = a - b;
        end else if (opc == OPC_OP_IMM) begin
            case (f3)
                3'b000:  res = a + b;
                3'b100:  res = a ^ b;
                3'b110:  res = a | b;
                3'b111:  res = a & b;
                default: writes = 1'b0;
            endcase
        end else begin
            writes = 1'b0;
        end
    endtask

    // --------------------------------------------------
    // Driver tasks called 1 ns after a rising edge
    // --------------------------------------------------
    task automatic send(input logic [31:0] ins, input logic raw);
        logic        writes;
        logic [31:0] res;
        logic        done;
        predict(ins, writes, res);
        instr_valid_i = 1'b1;
        instr_i = ins;
        acc_rd = ins[11:7];
        acc_writes = writes && ins[11:7] != 5'd0;
        acc_raw = raw;
        done = 1'b0;
        while (!done) begin
            // stall_o only moves at edges
            if (!stall_o) begin
                if (acc_writes) begin
                    exp_rd[wb_tail[7:0]] = acc_rd;
                    exp_data[wb_tail[7:0]] = res;
                    wb_tail = wb_tail + 1;
                    mirror[acc_rd] = res;
                end
                done = 1'b1;
            end
            @(posedge clk_i);
            #1;
        end
        sent_count++;
    endtask

    task automatic idle(input int cycles);
        instr_valid_i = 1'b0;
        acc_writes = 1'b0;
        acc_raw = 1'b0;
        repeat (cycles) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // Wait until every expected write-back has landed
    task automatic drain();
        idle(1);
        while (wb_head != wb_tail) begin
            @(posedge clk_i);
            #1;
        end
        idle(1);
    endtask

    task automatic finish_test(input string name);
        drain();
        if (fail_count == test_start_fails) begin
            $display("test %0d %s: ok", test_num, name);
            tests_ok++;
        end else begin
            $display("test %0d %s: %0d check failures", test_num, name,
                fail_count - test_start_fails);
            tests_bad++;
        end
        test_num++;
        test_start_fails = fail_count;
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        int k;
        int round;
        rst_i = 1'b0;
        instr_valid_i = 1'b0;
        instr_i = '0;
        acc_writes = 1'b0;
        acc_rd = '0;
        acc_raw = 1'b0;
        timing_mode = 1'b0;
        seed = 32'h409b;
        wb_tail = 0;
        fail_count = 0;
        test_num = 1;
        test_start_fails = 0;
        tests_ok = 0;
        tests_bad = 0;
        sent_count = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            mirror[i] = '0;
        end
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b1;

        // Registers start at zero
        send(op_word(0, 5'd3, 5'd1, 5'd2, 12'h0), 1'b0);
        finish_test("reset and zero ADD");

        // Random sources in x1..x6 and results in x7..x15
        for (k = 1; k <= 6; k++) begin
            send(enc_i(rand_imm(), F3_ADD_SUB, 5'(k), 5'd0), 1'b0);
        end
        for (round = 0; round < 2; round++) begin
            for (k = 0; k < 12; k++) begin
                send(op_word(k, pick_reg(7, 9), pick_reg(0, 16), pick_reg(0, 16), rand_imm()),
                    1'b0);
            end
        end
        finish_test("ALU operations");

        // Back to back without hazards
        timing_mode = 1'b1;
        for (k = 0; k < 8; k++) begin
            send(op_word(k, 5'(16 + k), pick_reg(1, 6), pick_reg(1, 6), rand_imm()), 1'b0);
        end
        timing_mode = 1'b0;
        finish_test("independent stream");

        // Chain of read-after-write hazards
        send(enc_i(rand_imm(), F3_ADD_SUB, 5'd20, 5'd1), 1'b0);
        send(op_word(0, 5'd21, 5'd20, 5'd2, 12'h0), 1'b1);
        send(op_word(1, 5'd22, 5'd21, 5'd20, 12'h0), 1'b1);
        send(enc_i(rand_imm(), F3_XOR, 5'd23, 5'd22), 1'b1);
        // Hazard on rs2 only
        send(op_word(0, 5'd24, 5'd3, 5'd23, 12'h0), 1'b1);
        finish_test("dependent instructions");

        send(enc_i(12'h055, F3_ADD_SUB, 5'd0, 5'd1), 1'b0);
        send(op_word(0, 5'd0, 5'd2, 5'd3, 12'h0), 1'b0);
        send(op_word(0, 5'd25, 5'd0, 5'd4, 12'h0), 1'b0);
        send(op_word(3, 5'd26, 5'd0, 5'd0, 12'h0), 1'b0);
        send(op_word(2, 5'd27, 5'd5, 5'd0, 12'h0), 1'b0);
        finish_test("x0 writes and reads");

        // Load, SRA, MUL and SLTI all retire as no-ops
        send({12'h004, 5'd1, 3'b010, 5'd5, 7'b0000011}, 1'b0);
        send(enc_r(F7_ALT, F3_SRL, 5'd6, 5'd1, 5'd2), 1'b0);
        send(enc_r(7'b0000001, F3_ADD_SUB, 5'd7, 5'd1, 5'd2), 1'b0);
        send(enc_i(12'h7ff, F3_SLT, 5'd8, 5'd1), 1'b0);
        send(op_word(0, 5'd28, 5'd5, 5'd6, 12'h0), 1'b0);
        send(op_word(0, 5'd29, 5'd7, 5'd8, 12'h0), 1'b0);
        finish_test("unsupported opcodes");

        $display("tests run %0d, clean %0d, failing %0d, check failures %0d",
            tests_ok + tests_bad, tests_ok, tests_bad, fail_count);
        if (fail_count == 0 && tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog sized from the instruction count
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Run timed out after %0d cycles with %0d instructions sent",
            WATCHDOG_CYCLES, sent_count);
        $display("test failed");
        $finish;
    end

endmodule

// File: issue_core.f
src/issue_pkg.sv
src/instr_decoder.sv
src/register_file.sv
src/alu_pipe.sv
src/issue_core.sv
testbench/tb_issue_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the issue core testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM=sim_issue_core

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_issue_core \
    -f issue_core.f \
    --Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
